// File: common/rs_params.svh
//****************************************************************************
// Sizing defines for the reservation station
//****************************************************************************
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// Station depth and index width, kept in step by hand
`define RS_ENTRIES	16
`define RS_IDX_W	4

// Physical register tag, 128 physical registers
`define PR_TAG_W	7

// Broadcast ports from the completion stage
`define CDB_PORTS	2

`endif

// File: common/rs_pkg.sv
//****************************************************************************
// Shared types: tags, unit classes, station op, dispatch, CDB and issue
//****************************************************************************
`default_nettype none

`include "rs_params.svh"

package rs_pkg;

	typedef logic [`PR_TAG_W-1:0] pr_tag_t;
	typedef logic [`RS_IDX_W-1:0] rs_idx_t;

	typedef enum logic [1:0]
	{
		FU_SIMPLE = 2'd0,
		FU_MUL    = 2'd1,
		FU_MEM    = 2'd2
	} fu_class_e;

	// Fields held per entry
	typedef struct packed
	{
		logic [31:0] ir;
		logic [4:0]  func;	// ALU function code
		fu_class_e   fu;
		pr_tag_t     dest;
		pr_tag_t     src_a;
		pr_tag_t     src_b;
	} rs_op_t;

	typedef struct packed
	{
		logic   valid;
		rs_op_t op;
		logic   ready_a;	// From the map table
		logic   ready_b;
	} dispatch_t;

	typedef struct packed
	{
		logic    valid;
		pr_tag_t tag;
	} cdb_t;

	typedef struct packed
	{
		logic        valid;
		logic [31:0] ir;
		logic [4:0]  func;
		pr_tag_t     dest;
		pr_tag_t     src_a;	// Read ports of the register file
		pr_tag_t     src_b;
	} issue_t;

endpackage

`default_nettype wire

// File: hw/rs/rs_alloc.sv
//****************************************************************************
// Free-entry search, occupancy count, dispatch acceptance
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_alloc
(
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     dispatch_valid,
	input  wire [`RS_ENTRIES-1:0]   release_vec,
	output logic                    dispatch_ready,
	output logic [`RS_ENTRIES-1:0]  alloc_onehot
);

	logic [`RS_ENTRIES-1:0] occupied;
	logic [`RS_ENTRIES-1:0] free_vec;
	logic [`RS_ENTRIES-1:0] lowest_free;
	logic [`RS_IDX_W:0]     count;
	logic [`RS_IDX_W:0]     num_released;

	assign free_vec    = ~occupied;
	assign lowest_free = free_vec & (~free_vec + 1'b1);	// Isolate lowest set bit

	// From registered state only, a same-cycle issue does not raise it
	assign dispatch_ready = (count != `RS_ENTRIES);
	assign alloc_onehot   = (dispatch_valid && dispatch_ready) ? lowest_free : '0;

	always_comb
	begin
		num_released = '0;
		for (int i = 0; i < `RS_ENTRIES; i++)
			num_released = num_released + {{`RS_IDX_W{1'b0}}, release_vec[i]};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			occupied <= '0;
			count    <= '0;
		end
		else
		begin
			occupied <= (occupied & ~release_vec) | alloc_onehot;
			count    <= count + {{`RS_IDX_W{1'b0}}, |alloc_onehot} - num_released;
		end
	end

	a_alloc_free: assert property (@(posedge clock) disable iff (reset)
		(dispatch_valid && dispatch_ready) |-> $onehot(alloc_onehot & ~occupied))
		else $error("rs_alloc: accepted dispatch without exactly one free entry");

	a_count: assert property (@(posedge clock) disable iff (reset)
		(count <= `RS_ENTRIES) && (count == $countones(occupied)))
		else $error("rs_alloc: occupancy count out of step");

endmodule

`default_nettype wire

// File: hw/rs/rs_entry_file.sv
//****************************************************************************
// Entry storage, operand wakeup from the CDB, per-class ready vectors
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_entry_file
	import rs_pkg::*;
(
	input  wire                          clock,
	input  wire                          reset,
	input  wire dispatch_t               dispatch,
	input  wire [`RS_ENTRIES-1:0]        alloc_onehot,
	input  wire cdb_t [`CDB_PORTS-1:0]   cdb,
	input  wire [`RS_ENTRIES-1:0]        grant_simple,
	input  wire [`RS_ENTRIES-1:0]        grant_mul,
	input  wire [`RS_ENTRIES-1:0]        grant_mem,
	output rs_op_t [`RS_ENTRIES-1:0]     ops,
	output logic [`RS_ENTRIES-1:0]       ready_simple,
	output logic [`RS_ENTRIES-1:0]       ready_mul,
	output logic [`RS_ENTRIES-1:0]       ready_mem,
	output logic [`RS_ENTRIES-1:0]       release_vec
);

	logic [`RS_ENTRIES-1:0] valid_q;
	logic [`RS_ENTRIES-1:0] ready_a_q;
	logic [`RS_ENTRIES-1:0] ready_b_q;
	logic [`RS_ENTRIES-1:0] both_ready;
	logic                   disp_ready_a;
	logic                   disp_ready_b;

	// Tag seen on any broadcast port this cycle
	function automatic logic cdb_hit(input pr_tag_t tag, input cdb_t [`CDB_PORTS-1:0] bus);
		logic hit;
		hit = 1'b0;
		for (int p = 0; p < `CDB_PORTS; p++)
			hit = hit | (bus[p].valid && (bus[p].tag == tag));
		return hit;
	endfunction

	// Same-cycle broadcast counts for the incoming op
	assign disp_ready_a = dispatch.ready_a | cdb_hit(dispatch.op.src_a, cdb);
	assign disp_ready_b = dispatch.ready_b | cdb_hit(dispatch.op.src_b, cdb);

	assign release_vec = grant_simple | grant_mul | grant_mem;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_q   <= '0;
			ready_a_q <= '0;
			ready_b_q <= '0;
		end
		else
		begin
			for (int i = 0; i < `RS_ENTRIES; i++)
			begin
				if (alloc_onehot[i])
				begin
					valid_q[i]   <= 1'b1;
					ready_a_q[i] <= disp_ready_a;
					ready_b_q[i] <= disp_ready_b;
				end
				else
				begin
					if (release_vec[i])
						valid_q[i] <= 1'b0;
					if (cdb_hit(ops[i].src_a, cdb))
						ready_a_q[i] <= 1'b1;	// Wakeup
					if (cdb_hit(ops[i].src_b, cdb))
						ready_b_q[i] <= 1'b1;
				end
			end
		end
	end

	// Payload only written on allocation
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `RS_ENTRIES; i++)
		begin
			if (alloc_onehot[i])
				ops[i] <= dispatch.op;
		end
	end

	assign both_ready = valid_q & ready_a_q & ready_b_q;

	always_comb
	begin
		for (int i = 0; i < `RS_ENTRIES; i++)
		begin
			ready_simple[i] = both_ready[i] && (ops[i].fu == FU_SIMPLE);
			ready_mul[i]    = both_ready[i] && (ops[i].fu == FU_MUL);
			ready_mem[i]    = both_ready[i] && (ops[i].fu == FU_MEM);
		end
	end

	// Selectors work on separate classes, so they never pick the same entry
	a_grants_disjoint: assert property (@(posedge clock) disable iff (reset)
		((grant_simple & grant_mul) | (grant_simple & grant_mem) | (grant_mul & grant_mem)) == '0)
		else $error("rs_entry_file: two units granted the same entry");

	a_grant_valid: assert property (@(posedge clock) disable iff (reset)
		(release_vec & ~valid_q) == '0)
		else $error("rs_entry_file: grant to an empty entry");

endmodule

`default_nettype wire

// File: hw/rs/rs_issue_select.sv
//****************************************************************************
// Lowest-index ready selection and issue handshake for one unit class
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_issue_select
	import rs_pkg::*;
(
	input  wire [`RS_ENTRIES-1:0]          ready_vec,
	input  wire rs_op_t [`RS_ENTRIES-1:0]  ops,
	input  wire                            fu_ready,
	output issue_t                         issue,
	output logic [`RS_ENTRIES-1:0]         grant
);

	rs_idx_t sel_idx;
	rs_op_t  sel_op;
	logic    any_ready;

	// Priority encoder, scanning down so the lowest index wins
	always_comb
	begin
		sel_idx = '0;
		for (int i = `RS_ENTRIES-1; i >= 0; i--)
		begin
			if (ready_vec[i])
				sel_idx = rs_idx_t'(i);
		end
	end

	assign any_ready = |ready_vec;
	assign sel_op    = ops[sel_idx];

	// Held steady while the unit is busy since entry state does not change
	always_comb
	begin
		issue.valid = any_ready;
		issue.ir    = sel_op.ir;
		issue.func  = sel_op.func;
		issue.dest  = sel_op.dest;
		issue.src_a = sel_op.src_a;
		issue.src_b = sel_op.src_b;
	end

	assign grant = (any_ready && fu_ready) ? (`RS_ENTRIES'(1) << sel_idx) : '0;

	// Lowest set bit of the ready vector, and only when the unit accepts
	always_comb
	begin
		a_grant_lowest: assert (grant == (fu_ready ? (ready_vec & (~ready_vec + 1'b1)) : '0))
			else $error("rs_issue_select: grant is not the lowest ready entry");
	end

endmodule

`default_nettype wire

// File: hw/rs/rs_top.sv
//****************************************************************************
// Reservation station top: allocation, entry file, three issue selectors
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_top
	import rs_pkg::*;
(
	input  wire                          clock,
	input  wire                          reset,
	input  wire dispatch_t               dispatch,
	output logic                         dispatch_ready,
	input  wire cdb_t [`CDB_PORTS-1:0]   cdb,
	input  wire [2:0]                    fu_ready,	// Indexed by fu_class_e
	output issue_t                       issue_simple,
	output issue_t                       issue_mul,
	output issue_t                       issue_mem
);

	logic [`RS_ENTRIES-1:0]   alloc_onehot;
	logic [`RS_ENTRIES-1:0]   release_vec;
	rs_op_t [`RS_ENTRIES-1:0] ops;
	logic [`RS_ENTRIES-1:0]   ready_simple;
	logic [`RS_ENTRIES-1:0]   ready_mul;
	logic [`RS_ENTRIES-1:0]   ready_mem;
	logic [`RS_ENTRIES-1:0]   grant_simple;
	logic [`RS_ENTRIES-1:0]   grant_mul;
	logic [`RS_ENTRIES-1:0]   grant_mem;

	rs_alloc i_alloc
	(
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch.valid),
		.release_vec    (release_vec),
		.dispatch_ready (dispatch_ready),
		.alloc_onehot   (alloc_onehot)
	);

	rs_entry_file i_entry_file
	(
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.alloc_onehot (alloc_onehot),
		.cdb          (cdb),
		.grant_simple (grant_simple),
		.grant_mul    (grant_mul),
		.grant_mem    (grant_mem),
		.ops          (ops),
		.ready_simple (ready_simple),
		.ready_mul    (ready_mul),
		.ready_mem    (ready_mem),
		.release_vec  (release_vec)
	);

	// One selector per unit class, all reading the same entries
	rs_issue_select i_sel_simple
	(
		.ready_vec (ready_simple),
		.ops       (ops),
		.fu_ready  (fu_ready[FU_SIMPLE]),
		.issue     (issue_simple),
		.grant     (grant_simple)
	);

	rs_issue_select i_sel_mul
	(
		.ready_vec (ready_mul),
		.ops       (ops),
		.fu_ready  (fu_ready[FU_MUL]),
		.issue     (issue_mul),
		.grant     (grant_mul)
	);

	rs_issue_select i_sel_mem
	(
		.ready_vec (ready_mem),
		.ops       (ops),
		.fu_ready  (fu_ready[FU_MEM]),
		.issue     (issue_mem),
		.grant     (grant_mem)
	);

endmodule

`default_nettype wire

// File: tb/rs_tb.sv
//****************************************************************************
// Reservation station testbench: clock, reset, file-driven stimulus, checks
//****************************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "rs_params.svh"

module rs_tb
	import rs_pkg::*;
();

	localparam int RESET_WAIT = 20;	// Cycles allowed for reset release
	localparam int MAX_CYCLES = 200;

	logic                  clock;
	logic                  reset;
	dispatch_t             dispatch;
	logic                  dispatch_ready;
	cdb_t [`CDB_PORTS-1:0] cdb;
	logic [2:0]            fu_ready;
	issue_t                issue_simple;
	issue_t                issue_mul;
	issue_t                issue_mem;

	// Source tags per dispatched dest tag
	pr_tag_t src_a_of [1 << `PR_TAG_W];
	pr_tag_t src_b_of [1 << `PR_TAG_W];

	int errors;
	int checks;

	rs_top i_dut
	(
		.clock          (clock),
		.reset          (reset),
		.dispatch       (dispatch),
		.dispatch_ready (dispatch_ready),
		.cdb            (cdb),
		.fu_ready       (fu_ready),
		.issue_simple   (issue_simple),
		.issue_mul      (issue_mul),
		.issue_mem      (issue_mem)
	);

	always #10 clock = ~clock;

	// Instruction word tied to the dest tag so the issued word can be checked
	function automatic logic [31:0] op_word(input pr_tag_t dest);
		return 32'ha53c_0000 | 32'(dest);
	endfunction

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic check_issue(input issue_t port, input logic [31:0] exp_valid,
		input logic [31:0] exp_dest, input string name, input int line_no);
		compare(32'(port.valid), exp_valid, $sformatf("line %0d %s issue valid", line_no, name));
		if (exp_valid[0])
		begin
			compare(32'(port.dest), exp_dest, $sformatf("line %0d %s dest", line_no, name));
			compare(port.ir, op_word(exp_dest[`PR_TAG_W-1:0]),
				$sformatf("line %0d %s instruction word", line_no, name));
			compare(32'(port.func), 32'(exp_dest[4:0]),
				$sformatf("line %0d %s func", line_no, name));
			compare(32'(port.src_a), 32'(src_a_of[exp_dest[`PR_TAG_W-1:0]]),
				$sformatf("line %0d %s src_a", line_no, name));
			compare(32'(port.src_b), 32'(src_b_of[exp_dest[`PR_TAG_W-1:0]]),
				$sformatf("line %0d %s src_b", line_no, name));
		end
	endtask

	// One file line per clock cycle, outputs checked at the falling edge
	task automatic run_stimulus(input int fd);
		string       line;
		int          n;
		int          line_no;
		int          cycles;
		logic        done;
		logic [31:0] d_v, d_fu, d_dest, d_sa, d_ra, d_sb, d_rb;
		logic [31:0] c0_v, c0_tag, c1_v, c1_tag;
		logic [31:0] rdy_s, rdy_m, rdy_e;
		logic [31:0] exp_drdy, exp_sv, exp_sdest, exp_mv, exp_mdest, exp_ev, exp_edest;
		done    = 1'b0;
		line_no = 0;
		cycles  = 0;
		while (!done && cycles < MAX_CYCLES)
		begin
			line_no++;
			if ($fgets(line, fd) == 0)
				done = 1'b1;
			else if (line.len() > 1 && line.getc(0) != "#")
			begin
				n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
					d_v, d_fu, d_dest, d_sa, d_ra, d_sb, d_rb,
					c0_v, c0_tag, c1_v, c1_tag, rdy_s, rdy_m, rdy_e,
					exp_drdy, exp_sv, exp_sdest, exp_mv, exp_mdest, exp_ev, exp_edest);
				if (n != 21)
				begin
					$display("Stimulus line %0d is malformed, %0d fields read", line_no, n);
					errors++;
				end
				else
				begin
					dispatch.valid      <= d_v[0];
					dispatch.op.ir      <= op_word(d_dest[`PR_TAG_W-1:0]);
					dispatch.op.func    <= d_dest[4:0];
					dispatch.op.fu      <= fu_class_e'(d_fu[1:0]);
					dispatch.op.dest    <= d_dest[`PR_TAG_W-1:0];
					dispatch.op.src_a   <= d_sa[`PR_TAG_W-1:0];
					dispatch.op.src_b   <= d_sb[`PR_TAG_W-1:0];
					dispatch.ready_a    <= d_ra[0];
					dispatch.ready_b    <= d_rb[0];
					cdb[0].valid        <= c0_v[0];
					cdb[0].tag          <= c0_tag[`PR_TAG_W-1:0];
					cdb[1].valid        <= c1_v[0];
					cdb[1].tag          <= c1_tag[`PR_TAG_W-1:0];
					fu_ready            <= {rdy_e[0], rdy_m[0], rdy_s[0]};
					if (d_v[0])
					begin
						src_a_of[d_dest[`PR_TAG_W-1:0]] = d_sa[`PR_TAG_W-1:0];
						src_b_of[d_dest[`PR_TAG_W-1:0]] = d_sb[`PR_TAG_W-1:0];
					end
					@(negedge clock);
					compare(32'(dispatch_ready), exp_drdy,
						$sformatf("line %0d dispatch_ready", line_no));
					check_issue(issue_simple, exp_sv, exp_sdest, "simple", line_no);
					check_issue(issue_mul, exp_mv, exp_mdest, "mul", line_no);
					check_issue(issue_mem, exp_ev, exp_edest, "mem", line_no);
					@(posedge clock);
					cycles++;
				end
			end
		end
		if (!done)
		begin
			$display("Stimulus loop timed out after %0d cycles", cycles);
			errors++;
		end
	endtask

	initial
	begin
		int fd;
		int wait_cycles;
		$timeformat(-9, 1, " ns", 10);
		errors   = 0;
		checks   = 0;
		clock    = 1'b0;
		reset    = 1'b1;
		dispatch = '0;
		cdb      = '0;
		fu_ready = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		wait_cycles = 0;
		while (reset !== 1'b0 && wait_cycles < RESET_WAIT)
		begin
			@(posedge clock);
			wait_cycles++;
		end
		if (reset !== 1'b0)
		begin
			$display("Reset was not released within %0d cycles", RESET_WAIT);
			errors++;
		end
		else
		begin
			fd = $fopen("tb/rs_stimulus.txt", "r");
			if (fd == 0)
			begin
				$display("Could not open the stimulus file tb/rs_stimulus.txt");
				errors++;
			end
			else
			begin
				run_stimulus(fd);
				$fclose(fd);
			end
		end
		$display("Errors: %0d, checks: %0d", errors, checks);
		if (errors == 0 && checks > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/rs_stimulus.txt
# Hex columns: dv fu dst sa ra sb rb | cdb0 v tag, cdb1 v tag | fu_ready simple mul mem
# then expected: dispatch_ready, simple v dst, mul v dst, mem v dst (fu 0 simple 1 mul 2 mem)
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 0 00 0 00 0 00
1 0 10 01 1 02 1  0 00 0 00  1 1 1  1 0 00 0 00 0 00
1 1 11 01 1 02 1  0 00 0 00  1 1 1  1 1 10 0 00 0 00
1 2 12 03 1 04 1  0 00 0 00  1 1 1  1 0 00 1 11 0 00
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 0 00 0 00 1 12
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 0 00 0 00 0 00
1 0 20 40 0 01 1  0 00 0 00  1 1 1  1 0 00 0 00 0 00
0 0 00 00 0 00 0  0 00 1 44  1 1 1  1 0 00 0 00 0 00
0 0 00 00 0 00 0  1 40 0 00  1 1 1  1 0 00 0 00 0 00
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 1 20 0 00 0 00
1 1 21 01 1 41 0  0 00 1 41  1 1 1  1 0 00 0 00 0 00
1 2 22 42 0 43 0  0 00 0 00  1 1 1  1 0 00 1 21 0 00
0 0 00 00 0 00 0  1 42 1 43  1 1 1  1 0 00 0 00 0 00
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 0 00 0 00 1 22
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 0 00 0 00 0 00
1 0 30 05 1 06 1  0 00 0 00  0 1 1  1 0 00 0 00 0 00
1 0 31 05 1 06 1  0 00 0 00  0 1 1  1 1 30 0 00 0 00
1 0 32 05 1 06 1  0 00 0 00  0 1 1  1 1 30 0 00 0 00
1 1 33 05 1 06 1  0 00 0 00  0 0 1  1 1 30 0 00 0 00
1 2 34 05 1 06 1  0 00 0 00  0 0 1  1 1 30 1 33 0 00
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 1 30 1 33 1 34
1 0 35 05 1 06 1  0 00 0 00  1 1 1  1 1 31 0 00 0 00
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 1 35 0 00 0 00
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 1 32 0 00 0 00
0 0 00 00 0 00 0  0 00 0 00  1 1 1  1 0 00 0 00 0 00
1 1 50 07 1 08 1  0 00 0 00  0 0 0  1 0 00 0 00 0 00
1 1 51 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 52 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 53 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 54 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 55 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 56 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 57 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 58 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 59 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 5a 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 5b 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 5c 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 5d 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 5e 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 5f 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 50 0 00
1 1 60 07 1 08 1  0 00 0 00  0 0 0  0 0 00 1 50 0 00
1 1 60 07 1 08 1  0 00 0 00  0 1 0  0 0 00 1 50 0 00
1 1 60 07 1 08 1  0 00 0 00  0 0 0  1 0 00 1 51 0 00
0 0 00 00 0 00 0  0 00 0 00  0 0 0  0 0 00 1 60 0 00

// File: sim.f
+incdir+common
common/rs_pkg.sv
hw/rs/rs_alloc.sv
hw/rs/rs_entry_file.sv
hw/rs/rs_issue_select.sv
hw/rs/rs_top.sv
tb/rs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the reservation station testbench.
# Runs from the project root so the stimulus path resolves.

cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rs_tb -o rs_sim || exit 1
result=$(./obj_dir/rs_sim)
echo "$result"
echo "$result" | grep -q "^STATUS: PASS$" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}
